//--- source/lc3b_types.sv
`default_nettype none

package lc3b_types;

	localparam int NUM_REGS = 8;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// n, z, p
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_lea = 4'b1110
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_alu_op;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_alu_op alu_op;
		logic sr2_imm;
		logic mem_read;
		logic mem_write;
		logic ld_reg;
		logic ld_cc;
		logic is_branch;
	} lc3b_control_word;

	typedef struct packed {
		logic valid;
		lc3b_word npc;
		lc3b_word ir;
		lc3b_control_word cw;
		lc3b_word sr1;
		lc3b_word sr2;
		lc3b_reg dr;
		lc3b_word address;
		lc3b_word result;
	} lc3b_stage_t;

endpackage : lc3b_types

`default_nettype wire

//--- source/lc3b_mem_types.sv
`default_nettype none

package lc3b_mem_types;

	localparam int WORDS_PER_BLOCK = 8;

	// byte offset inside a block
	localparam int OFFSET_BITS = 4;

	typedef logic [16*WORDS_PER_BLOCK-1:0] lc3b_c_block;

endpackage : lc3b_mem_types

`default_nettype wire

//--- source/mem_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if import lc3b_types::*; ();
	lc3b_word address;
	logic read;
	logic write;
	lc3b_word wdata;
	lc3b_word rdata;
	logic resp;

	// request held until resp pulses
	modport requester (
		output address, read, write, wdata,
		input rdata, resp
	);

	modport arbiter (
		input address, read, write, wdata,
		output rdata, resp
	);
endinterface : mem_port_if

`default_nettype wire

//--- source/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic load_regs,
	input logic dep_stall,
	input logic branch_taken,
	input lc3b_word target_pc,
	mem_port_if.requester imem,
	output lc3b_stage_t fd
);
	lc3b_word pc;
	lc3b_word ir_buf;
	logic buf_valid;
	lc3b_word instr;

	assign imem.address = pc;
	assign imem.read = !buf_valid;
	assign imem.write = 1'b0;
	assign imem.wdata = '0;

	// word arrives now or was parked while the pipe was held
	assign instr = buf_valid ? ir_buf : imem.rdata;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
			buf_valid <= 1'b0;
			fd <= '0;
		end else if (load_regs) begin
			if (branch_taken) begin
				pc <= target_pc;
				buf_valid <= 1'b0;
				fd.valid <= 1'b0;
			end else if (dep_stall) begin
				// decode keeps fd, so park the word at pc
				buf_valid <= 1'b1;
			end else begin
				pc <= pc + 16'd2;
				buf_valid <= 1'b0;
				fd.valid <= 1'b1;
				fd.npc <= pc + 16'd2;
				fd.ir <= instr;
			end
		end else if (imem.resp) begin
			buf_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (imem.resp)
			ir_buf <= imem.rdata;
	end

endmodule : fetch

`default_nettype wire

//--- source/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic load_regs,
	input lc3b_stage_t fd,
	input lc3b_stage_t ex_stage,
	input lc3b_stage_t wb_stage,
	input lc3b_word wb_data,
	output lc3b_stage_t de,
	output lc3b_nzp cc,
	output logic dep_stall
);
	lc3b_word regfile [NUM_REGS];
	lc3b_control_word cw;
	lc3b_opcode opcode;
	lc3b_reg sr1;
	lc3b_reg sr2;
	lc3b_reg dr;
	logic use_sr1;
	logic use_sr2;
	logic use_cc;
	lc3b_nzp wb_cc;

	function automatic logic writes_source(lc3b_stage_t s, lc3b_reg a, lc3b_reg b,
			logic use_a, logic use_b, logic use_codes);
		logic reg_hit;
		reg_hit = s.cw.ld_reg && ((use_a && s.dr == a) || (use_b && s.dr == b));
		return s.valid && (reg_hit || (use_codes && s.cw.ld_cc));
	endfunction

	assign opcode = lc3b_opcode'(fd.ir[15:12]);
	assign sr1 = fd.ir[8:6];
	assign dr = fd.ir[11:9];
	// str reads its data register from the dr field
	assign sr2 = (opcode == op_str) ? fd.ir[11:9] : fd.ir[2:0];
	assign use_cc = cw.is_branch;

	always_comb begin
		cw = '0;
		cw.opcode = opcode;
		cw.alu_op = alu_pass;
		use_sr1 = 1'b0;
		use_sr2 = 1'b0;
		case (opcode)
			op_add, op_and: begin
				cw.alu_op = (opcode == op_and) ? alu_and : alu_add;
				cw.sr2_imm = fd.ir[5];
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
				use_sr1 = 1'b1;
				use_sr2 = !fd.ir[5];
			end
			op_not: begin
				cw.alu_op = alu_not;
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
				use_sr1 = 1'b1;
			end
			op_lea: begin
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
			end
			op_ldr: begin
				cw.mem_read = 1'b1;
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
				use_sr1 = 1'b1;
			end
			op_str: begin
				cw.mem_write = 1'b1;
				use_sr1 = 1'b1;
				use_sr2 = 1'b1;
			end
			op_br: cw.is_branch = 1'b1;
			default: ;
		endcase
	end

	// older writers sit in de, ex and wb until the regfile is written
	assign dep_stall = fd.valid &&
		(writes_source(de, sr1, sr2, use_sr1, use_sr2, use_cc) ||
		writes_source(ex_stage, sr1, sr2, use_sr1, use_sr2, use_cc) ||
		writes_source(wb_stage, sr1, sr2, use_sr1, use_sr2, use_cc));

	assign wb_cc = wb_data[15] ? 3'b100 : (wb_data == '0) ? 3'b010 : 3'b001;

	always_ff @(posedge clk) begin
		if (load_regs && wb_stage.valid && wb_stage.cw.ld_reg)
			regfile[wb_stage.dr] <= wb_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cc <= 3'b010;
		end else if (load_regs && wb_stage.valid && wb_stage.cw.ld_cc) begin
			cc <= wb_cc;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			de <= '0;
		end else if (load_regs) begin
			// bubble into execute while stalled
			de.valid <= fd.valid && !dep_stall;
			de.npc <= fd.npc;
			de.ir <= fd.ir;
			de.cw <= cw;
			de.sr1 <= regfile[sr1];
			de.sr2 <= regfile[sr2];
			de.dr <= dr;
			de.address <= '0;
			de.result <= '0;
		end
	end

endmodule : decode

`default_nettype wire

//--- source/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic load_regs,
	input lc3b_stage_t de,
	input lc3b_nzp cc,
	output lc3b_stage_t ex,
	output logic branch_taken,
	output lc3b_word target_pc
);
	lc3b_word imm5;
	lc3b_word offset6;
	lc3b_word offset9;
	lc3b_word operand_b;
	lc3b_word address;
	lc3b_word alu_out;
	logic squash;
	logic live;

	assign imm5 = {{11{de.ir[4]}}, de.ir[4:0]};
	assign offset6 = {{9{de.ir[5]}}, de.ir[5:0], 1'b0};
	assign offset9 = {{6{de.ir[8]}}, de.ir[8:0], 1'b0};
	assign operand_b = de.cw.sr2_imm ? imm5 : de.sr2;

	assign address = (de.cw.opcode inside {op_lea, op_br}) ? de.npc + offset9
		: de.sr1 + offset6;

	always_comb begin
		case (de.cw.alu_op)
			alu_add: alu_out = de.sr1 + operand_b;
			alu_and: alu_out = de.sr1 & operand_b;
			alu_not: alu_out = ~de.sr1;
			default: alu_out = address;
		endcase
	end

	// the entry decoded next to a taken branch is dropped here
	assign live = de.valid && !squash;
	assign branch_taken = live && de.cw.is_branch && |(de.ir[11:9] & cc);
	assign target_pc = address;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			squash <= 1'b0;
			ex <= '0;
		end else if (load_regs) begin
			squash <= branch_taken;
			ex <= de;
			ex.valid <= live;
			ex.address <= address;
			ex.result <= alu_out;
		end
	end

endmodule : execute

`default_nettype wire

//--- source/mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb import lc3b_types::*; (
	input logic clk,
	input logic arst_n,
	input logic load_regs,
	input lc3b_stage_t ex,
	mem_port_if.requester dmem,
	output lc3b_stage_t wb,
	output lc3b_word wb_data
);
	// set once the access finished but the pipe is still held
	logic done;
	lc3b_word held_word;
	lc3b_word load_word;

	assign dmem.address = ex.address;
	assign dmem.read = ex.valid && ex.cw.mem_read && !done;
	assign dmem.write = ex.valid && ex.cw.mem_write && !done;
	assign dmem.wdata = ex.sr2;

	assign wb_data = wb.cw.mem_read ? load_word : wb.result;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			done <= 1'b0;
			wb <= '0;
		end else if (load_regs) begin
			done <= 1'b0;
			wb <= ex;
		end else if (dmem.resp) begin
			done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (dmem.resp)
			held_word <= dmem.rdata;
		if (load_regs)
			load_word <= done ? held_word : dmem.rdata;
	end

endmodule : mem_wb

`default_nettype wire

//--- source/arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module arbiter import lc3b_types::*; import lc3b_mem_types::*; (
	input logic clk,
	input logic arst_n,
	mem_port_if.arbiter imem,
	mem_port_if.arbiter dmem,
	input logic pmem_resp,
	input lc3b_c_block pmem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_word pmem_address,
	output lc3b_c_block pmem_wdata
);
	typedef enum logic [1:0] {
		s_idle,
		s_read,
		s_merge,
		s_write
	} state_t;

	state_t state;
	logic data_owner;
	lc3b_word sel_address;
	logic [$clog2(WORDS_PER_BLOCK)-1:0] word_idx;
	lc3b_word word;
	lc3b_c_block merged;

	assign sel_address = data_owner ? dmem.address : imem.address;
	assign word_idx = sel_address[OFFSET_BITS-1:1];
	assign pmem_address = {sel_address[15:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	assign pmem_read = (state == s_read) || (state == s_merge);
	assign pmem_write = (state == s_write);

	assign word = pmem_rdata[16*word_idx +: 16];
	assign imem.rdata = word;
	assign dmem.rdata = word;
	assign imem.resp = pmem_resp && !data_owner && (state == s_read);
	assign dmem.resp = pmem_resp && data_owner && ((state == s_read) || (state == s_write));

	// store word dropped into the block just read
	always_comb begin
		merged = pmem_rdata;
		merged[16*word_idx +: 16] = dmem.wdata;
	end

	always_ff @(posedge clk) begin
		if (state == s_merge && pmem_resp)
			pmem_wdata <= merged;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= s_idle;
			data_owner <= 1'b0;
		end else begin
			case (state)
				s_idle: begin
					// data side goes first, it is the older instruction
					if (dmem.write) begin
						data_owner <= 1'b1;
						state <= s_merge;
					end else if (dmem.read) begin
						data_owner <= 1'b1;
						state <= s_read;
					end else if (imem.read) begin
						data_owner <= 1'b0;
						state <= s_read;
					end
				end
				s_read: if (pmem_resp) state <= s_idle;
				s_merge: if (pmem_resp) state <= s_write;
				s_write: if (pmem_resp) state <= s_idle;
				default: state <= s_idle;
			endcase
		end
	end

endmodule : arbiter

`default_nettype wire

//--- source/mp3.sv
`timescale 1ns/1ps
`default_nettype none

module mp3 import lc3b_types::*; import lc3b_mem_types::*; (
	input logic clk,
	input logic arst_n,

	input logic pmem_resp,
	input lc3b_c_block pmem_rdata,

	output logic pmem_read,
	output logic pmem_write,
	output lc3b_word pmem_address,
	output lc3b_c_block pmem_wdata
);
	lc3b_stage_t fd;
	lc3b_stage_t de;
	lc3b_stage_t ex;
	lc3b_stage_t wb;
	lc3b_word wb_data;
	lc3b_word target_pc;
	lc3b_nzp cc;
	logic dep_stall;
	logic branch_taken;
	logic load_regs;

	mem_port_if ifetch ();
	mem_port_if dmem ();

	// whole pipe holds while either side waits on memory
	assign load_regs = !(ifetch.read && !ifetch.resp) &&
		!((dmem.read || dmem.write) && !dmem.resp);

	fetch fetch_int (
		.clk,
		.arst_n,
		.load_regs,
		.dep_stall,
		.branch_taken,
		.target_pc,
		.imem(ifetch),
		.fd
	);

	decode decode_int (
		.clk,
		.arst_n,
		.load_regs,
		.fd,
		.ex_stage(ex),
		.wb_stage(wb),
		.wb_data,
		.de,
		.cc,
		.dep_stall
	);

	execute execute_int (
		.clk,
		.arst_n,
		.load_regs,
		.de,
		.cc,
		.ex,
		.branch_taken,
		.target_pc
	);

	mem_wb mem_wb_int (
		.clk,
		.arst_n,
		.load_regs,
		.ex,
		.dmem(dmem),
		.wb,
		.wb_data
	);

	arbiter arbiter_int (
		.clk,
		.arst_n,
		.imem(ifetch),
		.dmem(dmem),
		.pmem_resp,
		.pmem_rdata,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata
	);

endmodule : mp3

`default_nettype wire

//--- dv/tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory import lc3b_types::*; import lc3b_mem_types::*; (
	input logic clk,
	input logic arst_n,
	input logic read,
	input logic write,
	input lc3b_word address,
	input lc3b_c_block wdata,
	output logic resp,
	output lc3b_c_block rdata
);
	localparam int LATENCY = 3;
	localparam int NUM_BLOCKS = 65536 / (2 * WORDS_PER_BLOCK);

	lc3b_c_block mem [NUM_BLOCKS];
	int wait_cycles;

	// odd multiplier, so every address gets its own word
	function automatic lc3b_word fill_word(lc3b_word a);
		return a * 16'h9e37 + 16'h3c5a;
	endfunction

	task automatic fill();
		for (int b = 0; b < NUM_BLOCKS; b++) begin
			for (int w = 0; w < WORDS_PER_BLOCK; w++)
				mem[b][16*w +: 16] = fill_word(16'(b * 2 * WORDS_PER_BLOCK + w * 2));
		end
	endtask

	task automatic poke(lc3b_word a, lc3b_word d);
		mem[a[15:OFFSET_BITS]][16*a[OFFSET_BITS-1:1] +: 16] = d;
	endtask

	function automatic lc3b_word peek(lc3b_word a);
		return mem[a[15:OFFSET_BITS]][16*a[OFFSET_BITS-1:1] +: 16];
	endfunction

	initial begin
		resp = 1'b0;
		rdata = '0;
		wait_cycles = 0;
	end

	// one response per request, LATENCY cycles after it shows up
	always @(negedge clk) begin
		if (!arst_n || resp) begin
			resp <= 1'b0;
			wait_cycles <= 0;
		end else if (read || write) begin
			if (wait_cycles == LATENCY - 1) begin
				resp <= 1'b1;
				if (write)
					mem[address[15:OFFSET_BITS]] <= wdata;
				else
					rdata <= mem[address[15:OFFSET_BITS]];
			end else begin
				wait_cycles <= wait_cycles + 1;
			end
		end else begin
			wait_cycles <= 0;
		end
	end

endmodule : tb_memory

`default_nettype wire

//--- dv/mp3_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mp3_tb import lc3b_types::*; import lc3b_mem_types::*; ();
	// upper bound on the words of all test programs
	localparam int PROGRAM_WORDS = 240;
	localparam lc3b_word LOOP_SELF = 16'h0FFF;

	logic clk;
	logic arst_n;
	logic pmem_resp;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	lc3b_c_block pmem_rdata;
	lc3b_c_block pmem_wdata;

	int mismatches;
	int failures;
	logic [31:0] lcg_state;

	lc3b_word prog [$];
	lc3b_word preload [lc3b_word];
	lc3b_word model_mem [lc3b_word];
	lc3b_word exp_addr [$];
	lc3b_word exp_word [$];
	lc3b_c_block exp_block [$];
	lc3b_word seen_addr [$];
	lc3b_c_block seen_block [$];

	mp3 i_mp3 (
		.clk,
		.arst_n,
		.pmem_resp,
		.pmem_rdata,
		.pmem_read,
		.pmem_write,
		.pmem_address,
		.pmem_wdata
	);

	tb_memory i_memory (
		.clk,
		.arst_n,
		.read(pmem_read),
		.write(pmem_write),
		.address(pmem_address),
		.wdata(pmem_wdata),
		.resp(pmem_resp),
		.rdata(pmem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		if (arst_n && pmem_write && pmem_resp) begin
			seen_addr.push_back(pmem_address);
			seen_block.push_back(pmem_wdata);
		end
	end

	initial begin
		#(PROGRAM_WORDS * 40 * 8);
		$display("timeout: the programs did not finish in time");
		$display("Some tests failed");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic lc3b_word add_rr(lc3b_reg d, lc3b_reg s1, lc3b_reg s2);
		return {4'b0001, d, s1, 3'b000, s2};
	endfunction

	function automatic lc3b_word add_ri(lc3b_reg d, lc3b_reg s1, int imm);
		return {4'b0001, d, s1, 1'b1, imm[4:0]};
	endfunction

	function automatic lc3b_word and_rr(lc3b_reg d, lc3b_reg s1, lc3b_reg s2);
		return {4'b0101, d, s1, 3'b000, s2};
	endfunction

	function automatic lc3b_word and_ri(lc3b_reg d, lc3b_reg s1, int imm);
		return {4'b0101, d, s1, 1'b1, imm[4:0]};
	endfunction

	function automatic lc3b_word not_r(lc3b_reg d, lc3b_reg s1);
		return {4'b1001, d, s1, 6'b111111};
	endfunction

	function automatic lc3b_word lea(lc3b_reg d, int off);
		return {4'b1110, d, off[8:0]};
	endfunction

	function automatic lc3b_word ldr(lc3b_reg d, lc3b_reg base, int off);
		return {4'b0110, d, base, off[5:0]};
	endfunction

	function automatic lc3b_word str(lc3b_reg s, lc3b_reg base, int off);
		return {4'b0111, s, base, off[5:0]};
	endfunction

	function automatic lc3b_word br(lc3b_nzp nzp, int off);
		return {4'b0000, nzp, off[8:0]};
	endfunction

	task automatic emit(lc3b_word w);
		prog.push_back(w);
	endtask

	// lea whose result is the given absolute address
	task automatic emit_lea_to(lc3b_reg d, int target);
		int off;
		off = (target - (prog.size() * 2 + 2)) / 2;
		emit(lea(d, off));
	endtask

	function automatic lc3b_word read_model_mem(lc3b_word a);
		return model_mem.exists(a) ? model_mem[a] : i_memory.peek(a);
	endfunction

	// sequential ISA model, collects the expected stores in order
	task automatic predict_stores();
		lc3b_word regs [NUM_REGS];
		lc3b_nzp cc;
		lc3b_word pc;
		lc3b_word npc;
		lc3b_word ir;
		lc3b_word val;
		lc3b_word b;
		lc3b_word a;
		lc3b_c_block blk;
		logic wr;
		int steps;
		for (int i = 0; i < NUM_REGS; i++)
			regs[i] = '0;
		cc = 3'b010;
		pc = '0;
		model_mem.delete();
		exp_addr.delete();
		exp_word.delete();
		exp_block.delete();
		for (steps = 0; steps < 1000; steps++) begin
			ir = read_model_mem(pc);
			if (ir == LOOP_SELF)
				break;
			npc = pc + 16'd2;
			pc = npc;
			wr = 1'b0;
			b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
			case (ir[15:12])
				4'b0001: begin
					val = regs[ir[8:6]] + b;
					wr = 1'b1;
				end
				4'b0101: begin
					val = regs[ir[8:6]] & b;
					wr = 1'b1;
				end
				4'b1001: begin
					val = ~regs[ir[8:6]];
					wr = 1'b1;
				end
				4'b1110: begin
					val = npc + {{6{ir[8]}}, ir[8:0], 1'b0};
					wr = 1'b1;
				end
				4'b0110: begin
					val = read_model_mem(regs[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0});
					wr = 1'b1;
				end
				4'b0111: begin
					a = regs[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
					model_mem[a] = regs[ir[11:9]];
					for (int w = 0; w < WORDS_PER_BLOCK; w++)
						blk[16*w +: 16] = read_model_mem({a[15:OFFSET_BITS], 4'(w * 2)});
					exp_addr.push_back(a);
					exp_word.push_back(regs[ir[11:9]]);
					exp_block.push_back(blk);
				end
				4'b0000: begin
					if (|(ir[11:9] & cc))
						pc = npc + {{6{ir[8]}}, ir[8:0], 1'b0};
				end
				default: begin
					failures++;
					$display("model met an unsupported opcode at %h", pc - 16'd2);
				end
			endcase
			if (wr) begin
				regs[ir[11:9]] = val;
				cc = val[15] ? 3'b100 : (val == '0) ? 3'b010 : 3'b001;
			end
		end
		if (steps >= 1000) begin
			failures++;
			$display("model never reached the closing loop");
		end
	endtask

	task automatic check_word(string name, lc3b_word got, lc3b_word exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_address(string name, lc3b_word got, lc3b_word exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_block(string name, lc3b_c_block got, lc3b_c_block exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic run_program(string name);
		int n;
		lc3b_word store_addr;
		@(negedge clk);
		arst_n = 1'b0;
		emit(LOOP_SELF);
		i_memory.fill();
		foreach (prog[i])
			i_memory.poke(16'(i * 2), prog[i]);
		foreach (preload[a])
			i_memory.poke(a, preload[a]);
		predict_stores();
		seen_addr.delete();
		seen_block.delete();
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		n = exp_addr.size();
		while (seen_addr.size() < n)
			@(posedge clk);
		// room for a store that should not be there
		repeat (60) @(posedge clk);
		if (seen_addr.size() != n) begin
			failures++;
			$display("%s: %0d block writes seen, %0d expected", name, seen_addr.size(), n);
		end
		for (int i = 0; i < n && i < seen_addr.size(); i++) begin
			store_addr = exp_addr[i];
			check_address({name, " pmem_address"}, seen_addr[i],
				{store_addr[15:OFFSET_BITS], {OFFSET_BITS{1'b0}}});
			check_word({name, " pmem_wdata word"},
				seen_block[i][16*store_addr[OFFSET_BITS-1:1] +: 16], exp_word[i]);
			check_block({name, " pmem_wdata"}, seen_block[i], exp_block[i]);
		end
		prog.delete();
		preload.delete();
	endtask

	task automatic alu_ops();
		emit_lea_to(6, 16'h0100);
		emit(and_ri(0, 0, 0));
		emit(add_ri(1, 0, 7));
		emit(add_ri(2, 0, -5));
		emit(add_rr(3, 1, 2));
		emit(and_rr(4, 1, 2));
		emit(not_r(5, 2));
		emit(add_ri(0, 1, -16));
		emit(and_ri(7, 2, -3));
		emit(str(3, 6, 0));
		emit(str(4, 6, 1));
		emit(str(5, 6, 2));
		emit(str(0, 6, 3));
		emit(str(7, 6, 4));
		run_program("alu");
	endtask

	task automatic load_store();
		preload[16'h0140] = 16'h1234;
		preload[16'h014A] = 16'hbeef;
		emit_lea_to(6, 16'h0140);
		emit(ldr(1, 6, 0));
		emit(ldr(2, 6, 5));
		emit(ldr(3, 6, 7));
		emit(str(1, 6, 3));
		emit(str(2, 6, 8));
		emit(ldr(4, 6, 3));
		emit(add_rr(5, 4, 3));
		emit(str(5, 6, 9));
		emit(ldr(0, 6, -2));
		emit(str(0, 6, 10));
		run_program("load_store");
	endtask

	task automatic dependent_chain();
		preload[16'h0160] = 16'h0321;
		emit_lea_to(6, 16'h0160);
		emit(ldr(1, 6, 0));
		emit(add_rr(1, 1, 1));
		emit(add_ri(1, 1, 1));
		emit(not_r(1, 1));
		emit(and_rr(2, 1, 1));
		emit(str(2, 6, 1));
		emit(ldr(3, 6, 1));
		emit(add_ri(3, 3, 3));
		emit(str(3, 6, 2));
		run_program("dependency");
	endtask

	task automatic branch_codes();
		preload[16'h0128] = 16'h1234;
		preload[16'h012C] = 16'h0000;
		emit_lea_to(6, 16'h0120);
		emit(and_ri(0, 0, 0));
		emit(br(3'b010, 1));
		emit(str(0, 6, 0));
		emit(add_ri(1, 0, -3));
		emit(br(3'b011, 1));
		emit(str(1, 6, 1));
		emit(br(3'b100, 1));
		emit(str(1, 6, 2));
		emit(ldr(2, 6, 4));
		emit(br(3'b001, 1));
		emit(str(2, 6, 3));
		emit(br(3'b110, 1));
		emit(str(2, 6, 5));
		emit(ldr(3, 6, 6));
		emit(br(3'b101, 1));
		emit(str(3, 6, 7));
		emit(br(3'b010, 1));
		emit(str(3, 6, 0));
		emit(add_ri(4, 2, 1));
		emit(str(4, 6, 9));
		run_program("branch");
	endtask

	task automatic lea_offsets();
		emit_lea_to(6, 16'h0110);
		emit(lea(1, -4));
		emit(lea(2, 100));
		emit(str(1, 6, 0));
		emit(str(2, 6, 1));
		emit(lea(4, -200));
		emit(br(3'b100, 1));
		emit(str(4, 6, 7));
		emit(str(4, 6, 2));
		emit_lea_to(5, 0);
		emit(br(3'b010, 1));
		emit(str(5, 6, 7));
		emit(str(5, 6, 3));
		emit(br(3'b001, 1));
		emit(str(5, 6, 4));
		run_program("lea");
	endtask

	task automatic random_pairs();
		lc3b_word a;
		for (int i = 0; i < 20; i++) begin
			a = 16'h0180 + 16'(i * 8);
			preload[a] = 16'(lcg_next() >> 16);
			preload[a + 16'd2] = 16'(lcg_next() >> 16);
		end
		emit_lea_to(6, 16'h0180);
		for (int i = 0; i < 20; i++) begin
			emit(ldr(1, 6, 0));
			emit(ldr(2, 6, 1));
			emit(add_rr(3, 1, 2));
			emit(and_rr(4, 1, 2));
			emit(str(3, 6, 2));
			emit(str(4, 6, 3));
			emit(add_ri(6, 6, 8));
		end
		run_program("random_pairs");
	endtask

	initial begin
		arst_n = 1'b0;
		mismatches = 0;
		failures = 0;
		lcg_state = 32'h879d_9353;
		alu_ops();
		load_store();
		dependent_chain();
		branch_codes();
		lea_offsets();
		random_pairs();
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule : mp3_tb

`default_nettype wire

//--- sim.f
source/lc3b_types.sv
source/lc3b_mem_types.sv
source/mem_port_if.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/mem_wb.sv
source/arbiter.sv
source/mp3.sv
dv/tb_memory.sv
dv/mp3_tb.sv
